// ==== rtl/streamer_pkg.sv ====
package streamer_pkg;

  // datapath widths
  localparam int unsigned DATA_W = 32;
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned LEN_W  = 16;   // word count and byte stride

  // response buffer depth per engine, also caps its outstanding requests
  localparam int unsigned BUF_DEPTH = 2;

  // requests that can be in flight on the shared port from both engines
  localparam int unsigned OUTST_MAX   = 2 * BUF_DEPTH;
  localparam int unsigned OUTST_PTR_W = $clog2(OUTST_MAX);
  localparam int unsigned OUTST_CNT_W = $clog2(OUTST_MAX + 1);

  // which load the streamer performs
  typedef enum logic [2:0] {
    LD_FEAT        = 3'd0,
    LD_WEIGHT      = 3'd1,
    LD_FEAT_WEIGHT = 3'd2,
    LD_NORM        = 3'd3,
    LD_STREAMIN    = 3'd4
  } ld_sel_e;

  // one engine's load description
  typedef struct packed {
    logic [ADDR_W-1:0] base;    // byte address of word 0
    logic [LEN_W-1:0]  stride;  // byte step between words
    logic [LEN_W-1:0]  len;     // number of words
  } load_cfg_t;

endpackage

// ==== rtl/mem_port_if.sv ====
`timescale 1ns/1ps

interface mem_port_if;

  import streamer_pkg::*;

  logic              req;     // request valid, held until gnt
  logic [ADDR_W-1:0] addr;    // stable while req && !gnt
  logic              gnt;
  logic              rvalid;  // one per granted request, in grant order
  logic [DATA_W-1:0] rdata;

  modport engine (
    output req,
    output addr,
    input  gnt,
    input  rvalid,
    input  rdata
  );

  modport arbiter (
    input  req,
    input  addr,
    output gnt,
    output rvalid,
    output rdata
  );

endinterface

// ==== rtl/word_stream_if.sv ====
`timescale 1ns/1ps

interface word_stream_if;

  import streamer_pkg::*;

  logic [DATA_W-1:0] data;
  logic              valid;
  logic              ready;
  logic              last;   // final word of a load

  modport source (
    output data,
    output valid,
    output last,
    input  ready
  );

  modport sink (
    input  data,
    input  valid,
    input  last,
    output ready
  );

endinterface

// ==== rtl/load_engine.sv ====
`timescale 1ns/1ps

module load_engine #(
  parameter int unsigned FIFO_DEPTH = streamer_pkg::BUF_DEPTH
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    start_i,
  input  streamer_pkg::load_cfg_t cfg_i,
  mem_port_if.engine              mem,
  word_stream_if.source           out
);

  import streamer_pkg::*;

  localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

  load_cfg_t         cfg_q;
  logic              active_q;
  logic [ADDR_W-1:0] addr_q;
  logic [LEN_W-1:0]  req_cnt_q;   // requests granted so far
  logic [LEN_W-1:0]  out_cnt_q;   // words handed out so far
  logic [CNT_W-1:0]  outst_q;     // granted, response not yet seen
  logic [CNT_W-1:0]  buf_cnt_q;
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [DATA_W-1:0] buf_q [FIFO_DEPTH];

  logic [CNT_W:0]    in_flight;
  logic              credit_ok;
  logic              req_fire;
  logic              buf_empty;
  logic              bypass;
  logic              push;
  logic              pop;
  logic              out_fire;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // every slot is either buffered or reserved by an outstanding request
  assign in_flight = buf_cnt_q + outst_q;
  assign credit_ok = in_flight < FIFO_DEPTH;

  assign mem.req   = active_q && (req_cnt_q != cfg_q.len) && credit_ok;
  assign mem.addr  = addr_q;
  assign req_fire  = mem.req & mem.gnt;

  assign buf_empty = (buf_cnt_q == '0);
  assign bypass    = buf_empty & mem.rvalid & out.ready;  // response goes straight out
  assign push      = mem.rvalid & ~bypass;
  assign pop       = ~buf_empty & out.ready;

  assign out.valid = ~buf_empty | mem.rvalid;
  assign out.data  = buf_empty ? mem.rdata : buf_q[rd_ptr_q];
  assign out.last  = (out_cnt_q == cfg_q.len - 1'b1);
  assign out_fire  = out.valid & out.ready;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cfg_q     <= '0;
      active_q  <= 1'b0;
      addr_q    <= '0;
      req_cnt_q <= '0;
      out_cnt_q <= '0;
      outst_q   <= '0;
      buf_cnt_q <= '0;
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
    end else begin
      if (start_i) begin
        cfg_q     <= cfg_i;
        active_q  <= 1'b1;
        addr_q    <= cfg_i.base;
        req_cnt_q <= '0;
        out_cnt_q <= '0;
      end else begin
        if (req_fire) begin
          addr_q    <= addr_q + ADDR_W'(cfg_q.stride);
          req_cnt_q <= req_cnt_q + 1'b1;
        end
        if (out_fire) begin
          out_cnt_q <= out_cnt_q + 1'b1;
          if (out.last) begin
            active_q <= 1'b0;   // idle until next start
          end
        end
      end
      outst_q   <= outst_q + CNT_W'(req_fire) - CNT_W'(mem.rvalid);
      buf_cnt_q <= buf_cnt_q + CNT_W'(push) - CNT_W'(pop);
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      buf_q[wr_ptr_q] <= mem.rdata;
    end
  end

  // responses that come back must always find room in the buffer
  a_credit_bound: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) in_flight <= FIFO_DEPTH
  ) else $error("load_engine: buffered plus outstanding exceeds %0d", FIFO_DEPTH);

endmodule

// ==== rtl/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  mem_port_if.arbiter                     act,
  mem_port_if.arbiter                     wt,
  output logic                            mem_req_o,
  output logic [streamer_pkg::ADDR_W-1:0] mem_addr_o,
  output logic                            mem_id_o,
  input  logic                            mem_gnt_i,
  input  logic                            mem_rvalid_i,
  input  logic                            mem_rid_i,
  input  logic [streamer_pkg::DATA_W-1:0] mem_rdata_i
);

  import streamer_pkg::*;

  logic                   prio_wt_q;   // weight engine wins the next tie
  logic                   sel_wt;
  logic                   grant;
  logic                   id_q [OUTST_MAX];
  logic [OUTST_PTR_W-1:0] id_wr_q;
  logic [OUTST_PTR_W-1:0] id_rd_q;
  logic [OUTST_CNT_W-1:0] id_cnt_q;

  // round robin only matters when both request
  assign sel_wt     = wt.req & (~act.req | prio_wt_q);
  assign mem_req_o  = act.req | wt.req;
  assign mem_addr_o = sel_wt ? wt.addr : act.addr;
  assign mem_id_o   = sel_wt;             // 0 act, 1 weight
  assign act.gnt    = mem_gnt_i & act.req & ~sel_wt;
  assign wt.gnt     = mem_gnt_i & sel_wt;
  assign grant      = mem_req_o & mem_gnt_i;

  // responses steered back by the echoed id
  assign act.rvalid = mem_rvalid_i & ~mem_rid_i;
  assign wt.rvalid  = mem_rvalid_i & mem_rid_i;
  assign act.rdata  = mem_rdata_i;
  assign wt.rdata   = mem_rdata_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      prio_wt_q <= 1'b0;
      id_wr_q   <= '0;
      id_rd_q   <= '0;
      id_cnt_q  <= '0;
    end else begin
      if (grant) begin
        prio_wt_q <= ~sel_wt;
        id_wr_q   <= (id_wr_q == OUTST_PTR_W'(OUTST_MAX - 1)) ? '0 : id_wr_q + 1'b1;
      end
      if (mem_rvalid_i) begin
        id_rd_q <= (id_rd_q == OUTST_PTR_W'(OUTST_MAX - 1)) ? '0 : id_rd_q + 1'b1;
      end
      id_cnt_q <= id_cnt_q + OUTST_CNT_W'(grant) - OUTST_CNT_W'(mem_rvalid_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (grant) begin
      id_q[id_wr_q] <= sel_wt;
    end
  end

  a_rvalid_outstanding: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) mem_rvalid_i |-> id_cnt_q != '0
  ) else $error("mem_arbiter: response with no request outstanding");

  // memory must answer in grant order
  a_rid_in_order: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) mem_rvalid_i |-> mem_rid_i == id_q[id_rd_q]
  ) else $error("mem_arbiter: response id out of grant order");

endmodule

// ==== rtl/load_dispatcher.sv ====
`timescale 1ns/1ps

module load_dispatcher (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            start_i,
  input  streamer_pkg::ld_sel_e           ld_sel_i,
  input  logic                            wmem_sel_i,
  output logic                            act_start_o,
  output logic                            wt_start_o,
  word_stream_if.sink                     act,
  word_stream_if.sink                     wt,
  output logic [streamer_pkg::DATA_W-1:0] feat_data_o,
  output logic                            feat_valid_o,
  output logic                            feat_last_o,
  input  logic                            feat_ready_i,
  output logic [streamer_pkg::DATA_W-1:0] weight_data_o,
  output logic                            weight_valid_o,
  output logic                            weight_last_o,
  input  logic                            weight_ready_i,
  output logic [streamer_pkg::DATA_W-1:0] norm_data_o,
  output logic                            norm_valid_o,
  output logic                            norm_last_o,
  input  logic                            norm_ready_i,
  output logic [streamer_pkg::DATA_W-1:0] streamin_data_o,
  output logic                            streamin_valid_o,
  output logic                            streamin_last_o,
  input  logic                            streamin_ready_i,
  output logic                            busy_o,
  output logic                            done_o
);

  import streamer_pkg::*;

  logic start_ok;
  logic run_act_d;
  logic run_wt_d;
  logic [3:0] route_d;   // {streamin, norm, weight, feat}
  logic run_act_q;
  logic run_wt_q;
  logic [3:0] route_q;
  logic act_done_q;
  logic wt_done_q;
  logic busy_q;
  logic done_q;
  logic act_end;
  logic wt_end;
  logic all_end;

  always_comb begin
    run_act_d = 1'b1;
    run_wt_d  = 1'b0;
    route_d   = 4'b0001;
    case (ld_sel_i)
      LD_WEIGHT: begin
        run_act_d = ~wmem_sel_i;
        run_wt_d  = wmem_sel_i;   // dedicated weight path
        route_d   = 4'b0010;
      end
      LD_FEAT_WEIGHT: run_wt_d = 1'b1;
      LD_NORM:        route_d  = 4'b0100;
      LD_STREAMIN:    route_d  = 4'b1000;
      default:        route_d  = 4'b0001;
    endcase
  end

  assign start_ok    = start_i & ~busy_q;   // ignored while busy
  assign act_start_o = start_ok & run_act_d;
  assign wt_start_o  = start_ok & run_wt_d;

  // activation stream fans out, valid picks the destination
  assign feat_data_o      = act.data;
  assign feat_last_o      = act.last;
  assign feat_valid_o     = act.valid & route_q[0];
  assign norm_data_o      = act.data;
  assign norm_last_o      = act.last;
  assign norm_valid_o     = act.valid & route_q[2];
  assign streamin_data_o  = act.data;
  assign streamin_last_o  = act.last;
  assign streamin_valid_o = act.valid & route_q[3];

  assign weight_data_o  = run_wt_q ? wt.data : act.data;
  assign weight_last_o  = run_wt_q ? wt.last : act.last;
  assign weight_valid_o = run_wt_q ? wt.valid : act.valid & route_q[1];

  assign act.ready = (route_q[0] & feat_ready_i) | (route_q[2] & norm_ready_i) |
                     (route_q[3] & streamin_ready_i) |
                     (route_q[1] & ~run_wt_q & weight_ready_i);
  assign wt.ready  = run_wt_q & weight_ready_i;

  assign act_end = ~run_act_q | act_done_q | (act.valid & act.ready & act.last);
  assign wt_end  = ~run_wt_q | wt_done_q | (wt.valid & wt.ready & wt.last);
  assign all_end = busy_q & act_end & wt_end;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      run_act_q  <= 1'b0;
      run_wt_q   <= 1'b0;
      route_q    <= '0;
      act_done_q <= 1'b0;
      wt_done_q  <= 1'b0;
      busy_q     <= 1'b0;
      done_q     <= 1'b0;
    end else begin
      done_q <= all_end;
      if (start_ok) begin
        run_act_q  <= run_act_d;
        run_wt_q   <= run_wt_d;
        route_q    <= route_d;
        act_done_q <= 1'b0;
        wt_done_q  <= 1'b0;
        busy_q     <= 1'b1;
      end else if (all_end) begin
        busy_q <= 1'b0;
      end else begin
        act_done_q <= act_done_q | (act.valid & act.ready & act.last);
        wt_done_q  <= wt_done_q | (wt.valid & wt.ready & wt.last);
      end
    end
  end

  assign busy_o = busy_q;
  assign done_o = done_q;

  property p_hold(logic vld, logic rdy, logic [DATA_W-1:0] dat, logic lst);
    @(posedge clk_i) disable iff (!rst_n_i)
      vld && !rdy |=> vld && $stable(dat) && $stable(lst);
  endproperty

  a_feat_hold:     assert property (p_hold(feat_valid_o, feat_ready_i, feat_data_o,
                                           feat_last_o));
  a_weight_hold:   assert property (p_hold(weight_valid_o, weight_ready_i, weight_data_o,
                                           weight_last_o));
  a_norm_hold:     assert property (p_hold(norm_valid_o, norm_ready_i, norm_data_o,
                                           norm_last_o));
  a_streamin_hold: assert property (p_hold(streamin_valid_o, streamin_ready_i,
                                           streamin_data_o, streamin_last_o));

endmodule

// ==== rtl/neureka_streamer_top.sv ====
`timescale 1ns/1ps

module neureka_streamer_top (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            start_i,
  input  streamer_pkg::ld_sel_e           ld_sel_i,
  input  logic                            wmem_sel_i,
  input  logic [streamer_pkg::ADDR_W-1:0] act_base_i,
  input  logic [streamer_pkg::LEN_W-1:0]  act_stride_i,
  input  logic [streamer_pkg::LEN_W-1:0]  act_len_i,
  input  logic [streamer_pkg::ADDR_W-1:0] wt_base_i,
  input  logic [streamer_pkg::LEN_W-1:0]  wt_stride_i,
  input  logic [streamer_pkg::LEN_W-1:0]  wt_len_i,
  output logic                            busy_o,
  output logic                            done_o,
  output logic                            mem_req_o,
  output logic [streamer_pkg::ADDR_W-1:0] mem_addr_o,
  output logic                            mem_id_o,
  input  logic                            mem_gnt_i,
  input  logic                            mem_rvalid_i,
  input  logic                            mem_rid_i,
  input  logic [streamer_pkg::DATA_W-1:0] mem_rdata_i,
  output logic [streamer_pkg::DATA_W-1:0] feat_data_o,
  output logic                            feat_valid_o,
  output logic                            feat_last_o,
  input  logic                            feat_ready_i,
  output logic [streamer_pkg::DATA_W-1:0] weight_data_o,
  output logic                            weight_valid_o,
  output logic                            weight_last_o,
  input  logic                            weight_ready_i,
  output logic [streamer_pkg::DATA_W-1:0] norm_data_o,
  output logic                            norm_valid_o,
  output logic                            norm_last_o,
  input  logic                            norm_ready_i,
  output logic [streamer_pkg::DATA_W-1:0] streamin_data_o,
  output logic                            streamin_valid_o,
  output logic                            streamin_last_o,
  input  logic                            streamin_ready_i
);

  import streamer_pkg::*;

  load_cfg_t act_cfg;
  load_cfg_t wt_cfg;
  logic      act_start;
  logic      wt_start;

  mem_port_if    act_mem ();
  mem_port_if    wt_mem ();
  word_stream_if act_stream ();
  word_stream_if wt_stream ();

  assign act_cfg = '{base: act_base_i, stride: act_stride_i, len: act_len_i};
  assign wt_cfg  = '{base: wt_base_i, stride: wt_stride_i, len: wt_len_i};

  // shared memory path
  load_engine i_act_engine (
    .clk_i   ( clk_i      ),
    .rst_n_i ( rst_n_i    ),
    .start_i ( act_start  ),
    .cfg_i   ( act_cfg    ),
    .mem     ( act_mem    ),
    .out     ( act_stream )
  );

  // dedicated weight path
  load_engine i_wt_engine (
    .clk_i   ( clk_i     ),
    .rst_n_i ( rst_n_i   ),
    .start_i ( wt_start  ),
    .cfg_i   ( wt_cfg    ),
    .mem     ( wt_mem    ),
    .out     ( wt_stream )
  );

  mem_arbiter i_mem_arbiter (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .act          ( act_mem      ),
    .wt           ( wt_mem       ),
    .mem_req_o    ( mem_req_o    ),
    .mem_addr_o   ( mem_addr_o   ),
    .mem_id_o     ( mem_id_o     ),
    .mem_gnt_i    ( mem_gnt_i    ),
    .mem_rvalid_i ( mem_rvalid_i ),
    .mem_rid_i    ( mem_rid_i    ),
    .mem_rdata_i  ( mem_rdata_i  )
  );

  load_dispatcher i_load_dispatcher (
    .clk_i            ( clk_i            ),
    .rst_n_i          ( rst_n_i          ),
    .start_i          ( start_i          ),
    .ld_sel_i         ( ld_sel_i         ),
    .wmem_sel_i       ( wmem_sel_i       ),
    .act_start_o      ( act_start        ),
    .wt_start_o       ( wt_start         ),
    .act              ( act_stream       ),
    .wt               ( wt_stream        ),
    .feat_data_o      ( feat_data_o      ),
    .feat_valid_o     ( feat_valid_o     ),
    .feat_last_o      ( feat_last_o      ),
    .feat_ready_i     ( feat_ready_i     ),
    .weight_data_o    ( weight_data_o    ),
    .weight_valid_o   ( weight_valid_o   ),
    .weight_last_o    ( weight_last_o    ),
    .weight_ready_i   ( weight_ready_i   ),
    .norm_data_o      ( norm_data_o      ),
    .norm_valid_o     ( norm_valid_o     ),
    .norm_last_o      ( norm_last_o      ),
    .norm_ready_i     ( norm_ready_i     ),
    .streamin_data_o  ( streamin_data_o  ),
    .streamin_valid_o ( streamin_valid_o ),
    .streamin_last_o  ( streamin_last_o  ),
    .streamin_ready_i ( streamin_ready_i ),
    .busy_o           ( busy_o           ),
    .done_o           ( done_o           )
  );

endmodule

// ==== verification/tb_streamer.sv ====
`timescale 1ns/1ps

module tb_streamer;

  import streamer_pkg::*;

  localparam logic [DATA_W-1:0] MEM_KEY = 32'h5a5a0000;  // memory data is address ^ key
  localparam int S_FEAT     = 0;
  localparam int S_WEIGHT   = 1;
  localparam int S_NORM     = 2;
  localparam int S_STREAMIN = 3;
  localparam int TEST_WORDS  = 6 + 4 + 5 + 4 + 5 + 6 + 7 + 12 + 10;  // words over all loads
  localparam int CYCLE_LIMIT = 10 * TEST_WORDS + 200;
  localparam load_cfg_t NO_LOAD = '0;

  typedef struct packed {
    logic [1:0]        s;     // output stream index
    logic              last;
    logic [DATA_W-1:0] data;
  } beat_t;

  logic clk_i = 1'b0;
  logic rst_n_i, start_i, wmem_sel_i, busy_o, done_o;
  ld_sel_e ld_sel_i;
  logic [ADDR_W-1:0] act_base_i, wt_base_i, mem_addr_o;
  logic [LEN_W-1:0]  act_stride_i, act_len_i, wt_stride_i, wt_len_i;
  logic mem_req_o, mem_id_o, mem_gnt_i, mem_rvalid_i, mem_rid_i;
  logic [DATA_W-1:0] mem_rdata_i, feat_data_o, weight_data_o, norm_data_o, streamin_data_o;
  logic feat_valid_o, feat_last_o, feat_ready_i, weight_valid_o, weight_last_o, weight_ready_i;
  logic norm_valid_o, norm_last_o, norm_ready_i;
  logic streamin_valid_o, streamin_last_o, streamin_ready_i;

  logic [31:0]       rng = 32'hc2b7;
  logic              rnd_ready = 1'b0;
  logic              pend_v = 1'b0;   // response due next cycle
  logic              pend_id = 1'b0;
  logic [ADDR_W-1:0] pend_addr = '0;
  logic              id_any = 1'b0;   // both engines may request
  logic              id_exp = 1'b0;   // id of the only running engine
  beat_t             recv [$];
  int                done_cnt = 0;
  int                done_before = 0;
  int                cycles = 0;

  neureka_streamer_top dut_i (.*);

  always #5 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic load_cfg_t make_cfg(input logic [ADDR_W-1:0] base,
                                         input logic [LEN_W-1:0] stride, len);
    return '{base: base, stride: stride, len: len};
  endfunction

  function automatic logic [DATA_W-1:0] expect_word(input load_cfg_t cfg, input int i);
    logic [ADDR_W-1:0] addr;
    addr = cfg.base + ADDR_W'(i) * ADDR_W'(cfg.stride);
    return addr ^ MEM_KEY;
  endfunction

  // memory model and sink readiness, all driven on the falling edge
  always @(negedge clk_i) begin
    rng          = xorshift(rng);
    mem_gnt_i    = rng[1:0] != 2'b00;
    mem_rvalid_i = pend_v;
    mem_rid_i    = pend_id;
    mem_rdata_i  = pend_addr ^ MEM_KEY;
    {feat_ready_i, weight_ready_i, norm_ready_i, streamin_ready_i} =
      rnd_ready ? rng[5:2] : 4'hf;
  end

  always @(posedge clk_i) begin
    pend_v    <= rst_n_i && mem_req_o && mem_gnt_i;
    pend_id   <= mem_id_o;
    pend_addr <= mem_addr_o;
    if (rst_n_i) begin
      if (mem_req_o && mem_gnt_i && !id_any) check_flag("mem_id_o", mem_id_o, id_exp);
      if (feat_valid_o && feat_ready_i) recv.push_back({2'd0, feat_last_o, feat_data_o});
      if (weight_valid_o && weight_ready_i) recv.push_back({2'd1, weight_last_o, weight_data_o});
      if (norm_valid_o && norm_ready_i) recv.push_back({2'd2, norm_last_o, norm_data_o});
      if (streamin_valid_o && streamin_ready_i)
        recv.push_back({2'd3, streamin_last_o, streamin_data_o});
      if (done_o) done_cnt++;
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, a load never finished", cycles);
      $display("Errors found");
      $fatal(1, "run stopped by cycle limit");
    end
  end

  task automatic abort_run();
    $display("Errors found");
    $fatal(1, "first mismatch ends the run");
  endtask

  task automatic check_word(input string name, input logic [DATA_W-1:0] got, exp);
    if (got !== exp) begin
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, exp);
    if (got !== exp) begin
      $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_count(input string name, input int got, exp);
    if (got != exp) begin
      $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_stream(input int s, input string name, input load_cfg_t cfg);
    int n = 0;
    foreach (recv[k]) begin
      if (recv[k].s == 2'(s)) begin
        check_word({name, "_data_o"}, recv[k].data, expect_word(cfg, n));
        check_flag({name, "_last_o"}, recv[k].last, n == int'(cfg.len) - 1);
        n++;
      end
    end
    check_count({name, " word count"}, n, int'(cfg.len));
  endtask

  task automatic check_streams(input load_cfg_t f, w, n, si);
    check_stream(S_FEAT, "feat", f);
    check_stream(S_WEIGHT, "weight", w);
    check_stream(S_NORM, "norm", n);
    check_stream(S_STREAMIN, "streamin", si);
  endtask

  task automatic start_load(input ld_sel_e sel, input logic wmem, input load_cfg_t a, w);
    @(negedge clk_i);
    ld_sel_i     = sel;
    wmem_sel_i   = wmem;
    id_any       = (sel == LD_FEAT_WEIGHT);
    id_exp       = (sel == LD_WEIGHT) && wmem;
    {act_base_i, act_stride_i, act_len_i} = a;
    {wt_base_i, wt_stride_i, wt_len_i}    = w;
    start_i      = 1'b1;
    recv.delete();
    done_before  = done_cnt;
    @(negedge clk_i);
    start_i = 1'b0;
    check_flag("busy_o", busy_o, 1'b1);
  endtask

  task automatic finish_load();
    while (done_cnt == done_before) @(negedge clk_i);
    repeat (4) @(negedge clk_i);   // quiet gap exposes stray words or pulses
    check_count("done_o pulses", done_cnt - done_before, 1);
    check_flag("busy_o", busy_o, 1'b0);
  endtask

  task automatic test_reset_state();
    check_flag("busy_o", busy_o, 1'b0);
    check_flag("done_o", done_o, 1'b0);
    check_flag("mem_req_o", mem_req_o, 1'b0);
    check_flag("feat_valid_o", feat_valid_o, 1'b0);
    check_flag("weight_valid_o", weight_valid_o, 1'b0);
    check_flag("norm_valid_o", norm_valid_o, 1'b0);
    check_flag("streamin_valid_o", streamin_valid_o, 1'b0);
  endtask

  task automatic test_feat();
    load_cfg_t a;
    a = make_cfg(32'h0000_1000, 16'd4, 16'd6);
    start_load(LD_FEAT, 1'b0, a, NO_LOAD);
    finish_load();
    check_streams(a, NO_LOAD, NO_LOAD, NO_LOAD);
  endtask

  task automatic test_norm_streamin();
    load_cfg_t n;
    load_cfg_t si;
    n  = make_cfg(32'h0000_2000, 16'd8, 16'd4);
    si = make_cfg(32'h0000_3004, 16'd4, 16'd5);
    start_load(LD_NORM, 1'b0, n, NO_LOAD);
    finish_load();
    check_streams(NO_LOAD, NO_LOAD, n, NO_LOAD);
    start_load(LD_STREAMIN, 1'b0, si, NO_LOAD);
    finish_load();
    check_streams(NO_LOAD, NO_LOAD, NO_LOAD, si);
  endtask

  // both configs loaded, wmem_sel_i picks which one reaches weight
  task automatic test_weight();
    load_cfg_t a;
    load_cfg_t w;
    a = make_cfg(32'h0000_4000, 16'd4, 16'd4);
    w = make_cfg(32'h0000_8000, 16'd16, 16'd5);
    start_load(LD_WEIGHT, 1'b0, a, w);
    finish_load();
    check_streams(NO_LOAD, a, NO_LOAD, NO_LOAD);
    start_load(LD_WEIGHT, 1'b1, a, w);
    finish_load();
    check_streams(NO_LOAD, w, NO_LOAD, NO_LOAD);
  endtask

  task automatic test_feat_weight();
    load_cfg_t a;
    load_cfg_t w;
    a = make_cfg(32'h0000_5000, 16'd4, 16'd6);
    w = make_cfg(32'h0000_9000, 16'd4, 16'd7);
    start_load(LD_FEAT_WEIGHT, 1'b0, a, w);
    finish_load();
    check_streams(a, w, NO_LOAD, NO_LOAD);
  endtask

  task automatic test_random_ready();
    load_cfg_t a;
    load_cfg_t w;
    a = make_cfg(32'h0000_6000, 16'd12, 16'd12);
    w = make_cfg(32'h0000_a000, 16'd8, 16'd10);
    rnd_ready = 1'b1;
    start_load(LD_FEAT_WEIGHT, 1'b0, a, w);
    @(negedge clk_i);
    check_flag("busy_o", busy_o, 1'b1);
    ld_sel_i = LD_NORM;   // second start while busy must be dropped
    start_i  = 1'b1;
    @(negedge clk_i);
    start_i = 1'b0;
    finish_load();
    rnd_ready = 1'b0;
    check_streams(a, w, NO_LOAD, NO_LOAD);
  endtask

  initial begin
    rst_n_i      = 1'b0;
    start_i      = 1'b0;
    ld_sel_i     = LD_FEAT;
    wmem_sel_i   = 1'b0;
    {act_base_i, act_stride_i, act_len_i} = '0;
    {wt_base_i, wt_stride_i, wt_len_i}    = '0;
    mem_gnt_i    = 1'b0;
    mem_rvalid_i = 1'b0;
    mem_rid_i    = 1'b0;
    mem_rdata_i  = '0;
    {feat_ready_i, weight_ready_i, norm_ready_i, streamin_ready_i} = 4'hf;
    repeat (16) @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);
    test_reset_state();
    test_feat();
    test_norm_streamin();
    test_weight();
    test_feat_weight();
    test_random_ready();
    $display("No errors");
    $finish;
  end

endmodule

// ==== verilog.f ====
rtl/streamer_pkg.sv
rtl/mem_port_if.sv
rtl/word_stream_if.sv
rtl/load_engine.sv
rtl/mem_arbiter.sv
rtl/load_dispatcher.sv
rtl/neureka_streamer_top.sv
verification/tb_streamer.sv

// ==== Bender.yml ====
package:
  name: neureka_streamer

sources:
  - rtl/streamer_pkg.sv
  - rtl/mem_port_if.sv
  - rtl/word_stream_if.sv
  - rtl/load_engine.sv
  - rtl/mem_arbiter.sv
  - rtl/load_dispatcher.sv
  - rtl/neureka_streamer_top.sv
  - target: simulation
    files:
      - verification/tb_streamer.sv
